//--- project.f
source/core_pkg.sv
source/ctrl_pkg.sv
source/pc_gen.sv
source/inst_fetch.sv
source/stall_ctrl.sv
source/if_id.sv
source/front_end_top.sv
sim/front_end_sva.sv
sim/front_end_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -f project.f --top-module front_end_tb \
    -o sim_front_end > build.log 2>&1 \
    && ./obj_dir/sim_front_end +verilator+error+limit+1000 > sim.log 2>&1

grep -q "^TESTS PASSED$" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see sim.log and build.log"; exit 1; }

//--- sim/front_end_tb.sv
//-------------------------------------------------
// testbench of the fetch front end
// memory model answers each request after 1 to 4 cycles
// checking lives in the bound front_end_sva module
//-------------------------------------------------
`timescale 1ns/1ps

module front_end_tb;

    import core_pkg::*;

    localparam time   clk_period = 8ns;
    localparam int    max_cycles = 2000;
    localparam inst_t data_mask  = 32'h5a5a_0000;

    logic  clk = 1'b0;
    logic  rst;
    logic  redirect_valid;
    pc_t   redirect_target;
    logic  mem_stall_sign;
    logic  ex_stall_sign;
    logic  id_stall_sign;
    logic  inst_req;
    pc_t   inst_addr;
    logic  inst_valid = 1'b0;
    inst_t inst_rdata = '0;
    pc_t   id_pc;
    inst_t id_inst;
    logic  if_inst_stall;

    // memory model state
    logic  req_seen;
    pc_t   req_addr_seen;
    bit    mem_busy = 1'b0;
    int    mem_cnt;
    pc_t   mem_addr;

    front_end_top front_end_top_inst (.*);

    bind front_end_top front_end_sva front_end_sva_inst (
        .clk             (clk),
        .rst             (rst),
        .redirect_valid  (redirect_valid),
        .redirect_target (redirect_target),
        .mem_stall_sign  (mem_stall_sign),
        .ex_stall_sign   (ex_stall_sign),
        .id_stall_sign   (id_stall_sign),
        .inst_req        (inst_req),
        .inst_addr       (inst_addr),
        .inst_valid      (inst_valid),
        .id_pc           (id_pc),
        .id_inst         (id_inst),
        .if_inst_stall   (if_inst_stall)
    );

    initial begin
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic inst_t mem_word(pc_t addr);
        return addr[31:0] ^ data_mask;
    endfunction

    // word aligned, low word stays in the 0x8xxx_xxxx range
    function automatic pc_t random_target();
        return reset_pc | pc_t'(($urandom % 65536) << 2);
    endfunction

    // requests are seen at the edge, answered on falling edges
    always @(posedge clk) begin
        req_seen      <= inst_req && !rst;
        req_addr_seen <= inst_addr;
    end

    always @(negedge clk) begin
        inst_valid = 1'b0;
        if (rst) begin
            mem_busy = 1'b0;
        end else if (mem_busy) begin
            if (mem_cnt == 1) begin
                inst_valid = 1'b1;
                inst_rdata = mem_word(mem_addr);
                mem_busy   = 1'b0;
            end else begin
                mem_cnt--;
            end
        end else if (req_seen) begin
            mem_busy = 1'b1;
            mem_cnt  = 1 + ($urandom % 4);
            mem_addr = req_addr_seen;
        end
    end

    task automatic random_traffic(int cycles);
        int stall_left;
        int sel;
        stall_left = 0;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            redirect_valid = 1'b0;
            if (stall_left == 0) begin
                mem_stall_sign = 1'b0;
                ex_stall_sign  = 1'b0;
                id_stall_sign  = 1'b0;
                if ($urandom % 8 == 0) begin
                    stall_left = 1 + ($urandom % 6);
                    sel = $urandom % 3;
                    if (sel == 0) id_stall_sign = 1'b1;
                    else if (sel == 1) ex_stall_sign = 1'b1;
                    else mem_stall_sign = 1'b1;
                end
            end else begin
                stall_left--;
            end
            if ($urandom % 24 == 0) begin
                redirect_valid  = 1'b1;
                redirect_target = random_target();
            end
        end
        @(negedge clk);
        redirect_valid = 1'b0;
        mem_stall_sign = 1'b0;
        ex_stall_sign  = 1'b0;
        id_stall_sign  = 1'b0;
    endtask

    // redirect in the middle of a decode stall
    task automatic flush_under_stall();
        @(negedge clk);
        id_stall_sign = 1'b1;
        repeat (3) @(negedge clk);
        redirect_valid  = 1'b1;
        redirect_target = random_target();
        @(negedge clk);
        redirect_valid = 1'b0;
        repeat (3) @(negedge clk);
        id_stall_sign = 1'b0;
        repeat (30) @(negedge clk);
    endtask

    // first assertion failure ends the run
    initial begin
        wait (front_end_top_inst.front_end_sva_inst.err_flag);
        if (front_end_top_inst.front_end_sva_inst.err_value)
            $display("mismatch at %0t: %s expected %h got %h",
                     front_end_top_inst.front_end_sva_inst.err_time,
                     front_end_top_inst.front_end_sva_inst.err_name,
                     front_end_top_inst.front_end_sva_inst.err_exp,
                     front_end_top_inst.front_end_sva_inst.err_got);
        else
            $display("error at %0t: %s",
                     front_end_top_inst.front_end_sva_inst.err_time,
                     front_end_top_inst.front_end_sva_inst.err_name);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first check failure");
    end

    initial begin
        #(max_cycles * clk_period);
        $display("timeout: run did not finish within %0d cycles", max_cycles);
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(32'h8283_db06));
        rst             = 1'b1;
        redirect_valid  = 1'b0;
        redirect_target = '0;
        mem_stall_sign  = 1'b0;
        ex_stall_sign   = 1'b0;
        id_stall_sign   = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        random_traffic(800);
        flush_under_stall();
        random_traffic(200);
        flush_under_stall();
        repeat (10) @(negedge clk);

        if (front_end_top_inst.front_end_sva_inst.err_flag) begin
            $display("TESTS FAILED");
            $fatal(1, "check failure at end of run");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

//--- sim/front_end_sva.sv
//-------------------------------------------------
// bound checks of the front end outputs
// memory data is assumed to be address low word ^ 32'h5a5a_0000
// first failure details are kept for the testbench to print
//-------------------------------------------------
`timescale 1ns/1ps

module front_end_sva (
    input logic            clk,
    input logic            rst,
    input logic            redirect_valid,
    input core_pkg::pc_t   redirect_target,
    input logic            mem_stall_sign,
    input logic            ex_stall_sign,
    input logic            id_stall_sign,
    input logic            inst_req,
    input core_pkg::pc_t   inst_addr,
    input logic            inst_valid,
    input core_pkg::pc_t   id_pc,
    input core_pkg::inst_t id_inst,
    input logic            if_inst_stall
);

    import core_pkg::*;

    localparam inst_t data_mask = 32'h5a5a_0000;

    bit    err_flag = 1'b0;
    bit    err_value;          // a compared value, not just an event
    string err_name;
    logic [63:0] err_exp;
    logic [63:0] err_got;
    time   err_time;

    pc_t   exp_pc;             // next pc decode should see
    pc_t   req_exp;            // address the next request must carry
    pc_t   prev_pc;
    inst_t prev_inst;
    logic  past_stall;
    logic  hold_due;
    logic  wait_due;
    logic  outstanding;        // request issued, reply not back
    logic  flush_owed;
    logic  new_delivery;

    function automatic inst_t expected_word(pc_t addr);
        return addr[31:0] ^ data_mask;
    endfunction

    function automatic void note_failure(string name, logic [63:0] exp_v,
                                         logic [63:0] got_v, bit is_value);
        if (!err_flag) begin
            err_name  = name;
            err_exp   = exp_v;
            err_got   = got_v;
            err_value = is_value;
            err_time  = $time;
            err_flag  = 1'b1;
        end
    endfunction

    assign new_delivery = (id_pc != zero_pc) && !past_stall;

    // a delivery seen now was fetched from the address before this request
    assign req_exp = new_delivery ? id_pc + pc_t'(4) : exp_pc;

    always_ff @(posedge clk) begin
        prev_pc    <= id_pc;
        prev_inst  <= id_inst;
        past_stall <= if_inst_stall && !rst;
        hold_due   <= if_inst_stall && !redirect_valid && !rst;
        wait_due   <= !if_inst_stall && outstanding && !inst_valid && !rst;
        if (rst) begin
            exp_pc      <= reset_pc;
            outstanding <= 1'b0;
            flush_owed  <= 1'b0;
        end else begin
            if (redirect_valid)
                exp_pc <= redirect_target;
            else if (new_delivery)
                exp_pc <= exp_pc + pc_t'(4);
            if (inst_req)
                outstanding <= 1'b1;
            else if (inst_valid)
                outstanding <= 1'b0;
            if (redirect_valid && if_inst_stall)
                flush_owed <= 1'b1;
            else if (!if_inst_stall)
                flush_owed <= 1'b0;
        end
    end

    a_reset_req: assert property (@(posedge clk) rst |-> !inst_req)
        else begin
            note_failure("inst_req raised during reset", 0, 0, 1'b0);
            $error("inst_req during reset");
        end

    a_reset_out: assert property (@(posedge clk) $fell(rst) |-> id_pc == zero_pc)
        else begin
            note_failure("id_pc", 0, $sampled(id_pc), 1'b1);
            $error("id_pc not cleared by reset");
        end

    a_reset_inst: assert property (@(posedge clk) $fell(rst) |-> id_inst == bubble_inst)
        else begin
            note_failure("id_inst", 0, 64'($sampled(id_inst)), 1'b1);
            $error("id_inst not cleared by reset");
        end

    a_pair: assert property (@(posedge clk) disable iff (rst)
        (id_inst != bubble_inst) |-> id_inst == expected_word(id_pc))
        else begin
            note_failure("id_inst", 64'(expected_word($sampled(id_pc))),
                         64'($sampled(id_inst)), 1'b1);
            $error("id_inst does not belong to id_pc");
        end

    a_order: assert property (@(posedge clk) disable iff (rst)
        new_delivery |-> id_pc == exp_pc)
        else begin
            note_failure("id_pc", $sampled(exp_pc), $sampled(id_pc), 1'b1);
            $error("id_pc out of program order");
        end

    a_req_addr: assert property (@(posedge clk) disable iff (rst)
        inst_req |-> inst_addr == req_exp)
        else begin
            note_failure("inst_addr", $sampled(req_exp), $sampled(inst_addr), 1'b1);
            $error("request address out of program order");
        end

    a_hold_pc: assert property (@(posedge clk) disable iff (rst)
        hold_due |-> id_pc == prev_pc)
        else begin
            note_failure("id_pc", $sampled(prev_pc), $sampled(id_pc), 1'b1);
            $error("id_pc changed under downstream stall");
        end

    a_hold_inst: assert property (@(posedge clk) disable iff (rst)
        hold_due |-> id_inst == prev_inst)
        else begin
            note_failure("id_inst", 64'($sampled(prev_inst)), 64'($sampled(id_inst)), 1'b1);
            $error("id_inst changed under downstream stall");
        end

    a_no_req: assert property (@(posedge clk) disable iff (rst)
        if_inst_stall |-> !inst_req)
        else begin
            note_failure("inst_req issued under downstream stall", 0, 0, 1'b0);
            $error("request under stall");
        end

    a_stall_or: assert property (@(posedge clk) disable iff (rst)
        if_inst_stall == (mem_stall_sign || ex_stall_sign || id_stall_sign))
        else begin
            note_failure("if_inst_stall",
                         64'($sampled(mem_stall_sign || ex_stall_sign || id_stall_sign)),
                         64'($sampled(if_inst_stall)), 1'b1);
            $error("if_inst_stall is not the OR of the stall signs");
        end

    a_wait: assert property (@(posedge clk) disable iff (rst)
        wait_due |-> id_inst == bubble_inst)
        else begin
            note_failure("id_inst", 0, 64'($sampled(id_inst)), 1'b1);
            $error("no bubble while fetch waits");
        end

    a_flush: assert property (@(posedge clk) disable iff (rst)
        (flush_owed && !if_inst_stall) |-> id_pc == zero_pc)
        else begin
            note_failure("id_pc", 0, $sampled(id_pc), 1'b1);
            $error("flush during stall was lost");
        end

endmodule

//--- source/front_end_top.sv
//-------------------------------------------------
// instruction fetch front end up to the decode boundary
// memory must answer each request once, 1 or more cycles later
//-------------------------------------------------
`timescale 1ns/1ps

module front_end_top (
    input  logic            clk,
    input  logic            rst,
    // from execute
    input  logic            redirect_valid,
    input  core_pkg::pc_t   redirect_target,
    // stage stall signs, levels
    input  logic            mem_stall_sign,
    input  logic            ex_stall_sign,
    input  logic            id_stall_sign,
    // instruction memory
    output logic            inst_req,
    output core_pkg::pc_t   inst_addr,
    input  logic            inst_valid,
    input  core_pkg::inst_t inst_rdata,
    // to decode
    output core_pkg::pc_t   id_pc,
    output core_pkg::inst_t id_inst,
    output logic            if_inst_stall
);

    import core_pkg::*;
    import ctrl_pkg::*;

    pc_t    fetch_pc;
    pc_t    done_pc;        // pc paired with fetch_inst
    inst_t  fetch_inst;
    logic   fetch_done;
    logic   fetch_wait;
    stall_t stall_vec;

    pc_gen pc_gen_inst (
        .clk             (clk),
        .rst             (rst),
        .stall_vec       (stall_vec),
        .fetch_done      (fetch_done),
        .redirect_valid  (redirect_valid),
        .redirect_target (redirect_target),
        .fetch_pc        (fetch_pc)
    );

    inst_fetch inst_fetch_inst (
        .clk            (clk),
        .rst            (rst),
        .fetch_pc       (fetch_pc),
        .stall_vec      (stall_vec),
        .redirect_valid (redirect_valid),
        .inst_valid     (inst_valid),
        .inst_rdata     (inst_rdata),
        .inst_req       (inst_req),
        .inst_addr      (inst_addr),
        .fetch_done     (fetch_done),
        .fetch_wait     (fetch_wait),
        .fetch_inst     (fetch_inst),
        .done_pc        (done_pc)
    );

    stall_ctrl stall_ctrl_inst (
        .mem_stall_sign (mem_stall_sign),
        .ex_stall_sign  (ex_stall_sign),
        .id_stall_sign  (id_stall_sign),
        .fetch_wait     (fetch_wait),
        .stall_vec      (stall_vec),
        .if_inst_stall  (if_inst_stall)
    );

    // redirect doubles as the IF/ID flush
    if_id if_id_inst (
        .clk         (clk),
        .rst         (rst),
        .if_pc       (done_pc),
        .if_inst     (fetch_inst),
        .if_load     (fetch_done),
        .if_id_flush (redirect_valid),
        .stall_ctrl  (stall_vec),
        .id_pc       (id_pc),
        .id_inst     (id_inst)
    );

endmodule

//--- source/if_id.sv
//-------------------------------------------------
// IF/ID pipeline register
// priority: reset, flush, fetch-only bubble, hold, load
// a flush seen under stall is kept until the stall is gone
//-------------------------------------------------
`timescale 1ns/1ps

module if_id (
    input  logic             clk,
    input  logic             rst,
    input  core_pkg::pc_t    if_pc,
    input  core_pkg::inst_t  if_inst,
    input  logic             if_load,
    input  logic             if_id_flush,
    input  ctrl_pkg::stall_t stall_ctrl,
    output core_pkg::pc_t    id_pc,
    output core_pkg::inst_t  id_inst
);

    import core_pkg::*;
    import ctrl_pkg::*;

    logic flush_pend;       // flush still owed to decode
    logic clear;
    logic if_only_stall;
    logic full_stall;
    logic front_stalled;
    logic front_free;

    assign clear         = if_id_flush || flush_pend;
    assign if_only_stall = stall_ctrl[stall_if] && !stall_ctrl[stall_id];
    assign full_stall    = &stall_ctrl[stall_id:stall_pc];
    assign front_stalled = (stall_ctrl[stall_if:stall_pc] == 2'b11);
    assign front_free    = (stall_ctrl[stall_if:stall_pc] == 2'b00);

    always_ff @(posedge clk) begin
        if (rst) begin
            id_pc   <= zero_pc;
            id_inst <= bubble_inst;
        end else if (clear) begin
            id_pc   <= zero_pc;
            id_inst <= bubble_inst;
        end else if (if_only_stall) begin
            id_pc   <= zero_pc;     // fetch still waiting
            id_inst <= bubble_inst;
        end else if (full_stall) begin
            id_pc   <= id_pc;
            id_inst <= id_inst;
        end else if (if_load) begin
            id_pc   <= if_pc;
            id_inst <= if_inst;
        end else begin
            // unstalled without a delivery, nothing valid to pass on
            id_pc   <= zero_pc;
            id_inst <= bubble_inst;
        end
    end

    // pending flush memory
    always_ff @(posedge clk) begin
        if (rst)
            flush_pend <= 1'b0;
        else if (if_id_flush && front_stalled)
            flush_pend <= 1'b1;
        else if (front_free)
            flush_pend <= 1'b0;
    end

endmodule

//--- source/stall_ctrl.sv
//-------------------------------------------------
// stall vector from the stage stall signs and the fetch wait
// the latest stalled stage decides, earlier bits follow
//-------------------------------------------------
`timescale 1ns/1ps

module stall_ctrl (
    input  logic             mem_stall_sign,
    input  logic             ex_stall_sign,
    input  logic             id_stall_sign,
    input  logic             fetch_wait,
    output ctrl_pkg::stall_t stall_vec,
    output logic             if_inst_stall
);

    import ctrl_pkg::*;

    always_comb begin
        stall_vec = '0;
        if (mem_stall_sign) begin
            stall_vec[stall_mem:stall_pc] = '1;
        end else if (ex_stall_sign) begin
            stall_vec[stall_ex:stall_pc] = '1;
        end else if (id_stall_sign) begin
            stall_vec[stall_id:stall_pc] = '1;
        end else if (fetch_wait) begin
            stall_vec[stall_if:stall_pc] = '1;    // fetch only, decode gets a bubble
        end
    end

    // any downstream stage busy
    assign if_inst_stall = mem_stall_sign | ex_stall_sign | id_stall_sign;

endmodule

//--- source/inst_fetch.sv
//-------------------------------------------------
// instruction fetch FSM with a single outstanding request
// memory must not answer without a request
// a reply seen under downstream stall is buffered until it clears
//-------------------------------------------------
`timescale 1ns/1ps

module inst_fetch (
    input  logic             clk,
    input  logic             rst,
    input  core_pkg::pc_t    fetch_pc,
    input  ctrl_pkg::stall_t stall_vec,
    input  logic             redirect_valid,
    input  logic             inst_valid,
    input  core_pkg::inst_t  inst_rdata,
    output logic             inst_req,
    output core_pkg::pc_t    inst_addr,
    output logic             fetch_done,
    output logic             fetch_wait,
    output core_pkg::inst_t  fetch_inst,
    output core_pkg::pc_t    done_pc
);

    import core_pkg::*;
    import ctrl_pkg::*;

    // port fetch_wait shadows the enum member of the same name
    fetch_state_t state;
    pc_t          req_pc;       // address of the request in flight
    logic         buf_valid;
    inst_t        buf_inst;
    logic         reply_avail;
    logic         in_wait;

    assign in_wait     = (state == ctrl_pkg::fetch_wait);
    assign reply_avail = inst_valid || buf_valid;

    // no issue in reset, nor in a redirect cycle while fetch_pc is still the old path
    assign inst_req  = !rst && (state == fetch_idle) && !stall_vec[stall_pc]
                       && !redirect_valid;
    assign inst_addr = fetch_pc;

    // delivery only needs decode to be free
    assign fetch_done = in_wait && reply_avail && !stall_vec[stall_id] && !redirect_valid;

    // low once a reply is at hand so the stall vector has no loop
    assign fetch_wait = (state == fetch_drop) || (in_wait && !reply_avail);

    assign fetch_inst = buf_valid ? buf_inst : inst_rdata;
    assign done_pc    = req_pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= fetch_idle;
            buf_valid <= 1'b0;
        end else begin
            case (state)
                fetch_idle: begin
                    if (inst_req)
                        state <= ctrl_pkg::fetch_wait;
                end
                ctrl_pkg::fetch_wait: begin
                    if (redirect_valid) begin
                        // stale reply already here, or still to come
                        state     <= reply_avail ? fetch_idle : fetch_drop;
                        buf_valid <= 1'b0;
                    end else if (fetch_done) begin
                        state     <= fetch_idle;
                        buf_valid <= 1'b0;
                    end else if (inst_valid) begin
                        buf_valid <= 1'b1;  // park it until the stall clears
                    end
                end
                fetch_drop: begin
                    if (inst_valid)
                        state <= fetch_idle;    // swallowed
                end
                default: state <= fetch_idle;
            endcase
        end
    end

    // request address and parked reply word
    always_ff @(posedge clk) begin
        if (inst_req)
            req_pc <= fetch_pc;
        if (in_wait && inst_valid)
            buf_inst <= inst_rdata;
    end

endmodule

//--- source/pc_gen.sv
//-------------------------------------------------
// fetch address register
// redirect wins over sequential advance, even under stall
// advances by four only on a delivered instruction
//-------------------------------------------------
`timescale 1ns/1ps

module pc_gen (
    input  logic             clk,
    input  logic             rst,
    input  ctrl_pkg::stall_t stall_vec,
    input  logic             fetch_done,
    input  logic             redirect_valid,
    input  core_pkg::pc_t    redirect_target,
    output core_pkg::pc_t    fetch_pc
);

    import core_pkg::*;
    import ctrl_pkg::*;

    logic  advance;
    pc_t   seq_pc;

    // next sequential word
    assign seq_pc  = fetch_pc + pc_t'(4);
    assign advance = fetch_done && !stall_vec[stall_pc];

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pc <= reset_pc;
        end else if (redirect_valid) begin
            fetch_pc <= redirect_target;    // branch from execute
        end else if (advance) begin
            fetch_pc <= seq_pc;
        end
    end

endmodule

//--- source/ctrl_pkg.sv
//-------------------------------------------------
// control definitions of the fetch front end
// stall vector has one bit per stage, bit 0 is the pc stage
// a stage stall always sets its own bit and every earlier bit
//-------------------------------------------------
package ctrl_pkg;

    typedef logic [4:0] stall_t;

    // stall vector bit positions
    localparam int stall_pc  = 0;
    localparam int stall_if  = 1;
    localparam int stall_id  = 2;
    localparam int stall_ex  = 3;
    localparam int stall_mem = 4;

    // fetch FSM, one outstanding request at most
    typedef enum logic [1:0] {
        fetch_idle = 2'd0,  // free to issue a request
        fetch_wait = 2'd1,  // request out, reply pending or buffered
        fetch_drop = 2'd2   // reply in flight belongs to the old path
    } fetch_state_t;

endpackage

//--- source/core_pkg.sv
//-------------------------------------------------
// datapath widths and constants of the fetch front end
// widths are fixed by the ISA, 64-bit pc and 32-bit instructions
// bubbles are all-zero pc and instruction, no valid bit
//-------------------------------------------------
package core_pkg;

    // widths
    localparam int pc_w   = 64;
    localparam int inst_w = 32;

    typedef logic [pc_w-1:0]   pc_t;
    typedef logic [inst_w-1:0] inst_t;

    // first fetch address after reset
    localparam pc_t reset_pc = 64'h8000_0000;

    // values shown to decode when no instruction is present
    localparam pc_t   zero_pc     = '0;
    localparam inst_t bubble_inst = '0;

endpackage
